// File: bkt_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// current level and backtrack sequence
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bkt_sequencer (
    input  logic                              clk,
    input  logic                              rst,
    input  sat_lvl_pkg::trail_cmd_t           cmd_i,
    input  sat_lvl_pkg::find_res_t            find_i,
    output logic [sat_lvl_pkg::WIDTH_LVL-1:0] cur_lvl_o,
    output logic                              apply_bkt_o,
    output logic                              clear_all_o,
    output logic                              busy_o,
    output logic                              unsat_o,
    output sat_lvl_pkg::find_res_t            result_o
);
    import sat_lvl_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CAPTURE,  // search settles, result taken at the end
        S_APPLY     // cells flip or clear
    } seq_state_t;

    seq_state_t           state_q;
    logic [WIDTH_LVL-1:0] cur_lvl_q;
    logic                 unsat_q;
    find_res_t            result_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q   <= S_IDLE;
            cur_lvl_q <= '0;
            unsat_q   <= 1'b0;
            result_q  <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (cmd_i.backtrack) begin
                        state_q <= S_CAPTURE;
                    end else if (cmd_i.decide) begin
                        if (cur_lvl_q < WIDTH_LVL'(NUM_LVLS))   // full trail ignores it
                            cur_lvl_q <= cur_lvl_q + WIDTH_LVL'(1);
                        unsat_q <= 1'b0;
                    end else if (cmd_i.load) begin
                        unsat_q <= 1'b0;
                    end
                end
                S_CAPTURE: begin
                    result_q <= find_i;
                    state_q  <= S_APPLY;
                end
                S_APPLY: begin
                    cur_lvl_q <= result_q.found ? result_q.bkt_lvl : '0;
                    unsat_q   <= !result_q.found;
                    state_q   <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    assign busy_o      = (state_q != S_IDLE);
    assign apply_bkt_o = (state_q == S_APPLY);
    assign clear_all_o = apply_bkt_o && !result_q.found;  // no level left
    assign cur_lvl_o   = cur_lvl_q;
    assign unsat_o     = unsat_q;
    assign result_o    = result_q;

    // the slave holds every command back while a backtrack runs
    a_no_cmd_busy: assert property (@(posedge clk) disable iff (!rst)
        busy_o |-> !(cmd_i.decide || cmd_i.backtrack || cmd_i.load));

endmodule

// File: lvl_state_array.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// chain of level cells, find merge and
// load / read access
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lvl_state_array (
    input  logic                              clk,
    input  logic                              rst,
    input  sat_lvl_pkg::trail_cmd_t           cmd_i,
    input  logic [sat_lvl_pkg::WIDTH_LVL-1:0] cur_lvl_i,
    input  logic                              apply_bkt_i,
    input  logic                              clear_all_i,
    input  logic [sat_lvl_pkg::WIDTH_LVL-1:0] rd_lvl_i,
    output sat_lvl_pkg::lvl_state_t           rd_state_o,
    output sat_lvl_pkg::find_res_t            find_o
);
    import sat_lvl_pkg::*;

    logic [WIDTH_LVL-1:0]    lvl_chain  [NUM_LVLS+1];
    logic [1:0]              flag_chain [NUM_LVLS+1];
    lvl_state_t              cell_state [NUM_LVLS];
    logic [WIDTH_BIN_ID-1:0] cell_bin   [NUM_LVLS];
    logic [WIDTH_LVL-1:0]    cell_lvl   [NUM_LVLS];
    logic [NUM_LVLS-1:0]     wr_en;
    lvl_state_t              wr_data;
    logic [WIDTH_BIN_ID-1:0] find_bin;
    logic [WIDTH_LVL-1:0]    find_lvl;

    assign lvl_chain[0]         = '0;
    assign flag_chain[NUM_LVLS] = 2'd0;       // top of the search chain
    assign wr_data              = clear_all_i ? '0 : cmd_i.state;

    for (genvar i = 0; i < NUM_LVLS; i++) begin : g_cell
        assign wr_en[i] = clear_all_i ||
                          (cmd_i.load && (cmd_i.lvl_sel == WIDTH_LVL'(i + 1)));

        lvl_state_cell u_cell (
            .clk         (clk),
            .rst         (rst),
            .dec_valid_i (cmd_i.decide),
            .cur_bin_i   (cmd_i.bin),
            .cur_lvl_i   (cur_lvl_i),
            .lvl_prev_i  (lvl_chain[i]),
            .lvl_prev_o  (lvl_chain[i+1]),
            .findflag_i  (flag_chain[i+1]),
            .findflag_o  (flag_chain[i]),
            .max_lvl_i   (cur_lvl_i),
            .apply_bkt_i (apply_bkt_i),
            .wr_state_i  (wr_en[i]),
            .state_i     (wr_data),
            .state_o     (cell_state[i]),
            .bkt_bin_o   (cell_bin[i]),
            .bkt_lvl_o   (cell_lvl[i])
        );
    end

    // only the found cell drives nonzero bin and level
    always_comb begin
        find_bin   = '0;
        find_lvl   = '0;
        rd_state_o = '0;
        for (int i = 0; i < NUM_LVLS; i++) begin
            find_bin = find_bin | cell_bin[i];
            find_lvl = find_lvl | cell_lvl[i];
            if (rd_lvl_i == WIDTH_LVL'(i + 1)) rd_state_o = cell_state[i];
        end
    end

    assign find_o = {flag_chain[0] != 2'd0, find_lvl, find_bin};

    // cells apply the same search that the sequencer captured
    a_find_stable: assert property (@(posedge clk) disable iff (!rst)
        apply_bkt_i |-> $stable(find_o));

endmodule

// File: lvl_state_cell.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one decision level: stored state plus
// its link in the backtrack search chain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lvl_state_cell (
    input  logic                                  clk,
    input  logic                                  rst,

    // decide
    input  logic                                  dec_valid_i,
    input  logic [sat_lvl_pkg::WIDTH_BIN_ID-1:0]  cur_bin_i,
    input  logic [sat_lvl_pkg::WIDTH_LVL-1:0]     cur_lvl_i,
    input  logic [sat_lvl_pkg::WIDTH_LVL-1:0]     lvl_prev_i,
    output logic [sat_lvl_pkg::WIDTH_LVL-1:0]     lvl_prev_o,

    // search chain, runs from the top level down
    input  logic [1:0]                            findflag_i,
    output logic [1:0]                            findflag_o,
    input  logic [sat_lvl_pkg::WIDTH_LVL-1:0]     max_lvl_i,
    input  logic                                  apply_bkt_i,

    // load and read
    input  logic                                  wr_state_i,
    input  sat_lvl_pkg::lvl_state_t               state_i,
    output sat_lvl_pkg::lvl_state_t               state_o,

    output logic [sat_lvl_pkg::WIDTH_BIN_ID-1:0]  bkt_bin_o,
    output logic [sat_lvl_pkg::WIDTH_LVL-1:0]     bkt_lvl_o
);
    import sat_lvl_pkg::*;

    logic [WIDTH_LVL-1:0] lvl_r;
    lvl_state_t           state_r;
    logic                 dec_hit;

    assign lvl_prev_o = lvl_prev_i + WIDTH_LVL'(1);
    assign state_o    = state_r;

    // own level number, one above the cell below
    always_ff @(posedge clk) begin
        if (!rst) begin
            lvl_r <= '0;
        end else begin
            lvl_r <= lvl_prev_o;
        end
    end

    // new decision goes one above the current level
    assign dec_hit = dec_valid_i && (lvl_r == cur_lvl_i + WIDTH_LVL'(1));

    // 2: found higher up, 1: this cell, 0: nothing yet
    assign findflag_o = (findflag_i != 2'd0) ? 2'd2 :
                        ((lvl_r <= max_lvl_i) && !state_r.has_bkt) ? 2'd1 : 2'd0;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_r <= '0;
        end else if (wr_state_i) begin
            state_r <= state_i;
        end else if (dec_hit) begin
            state_r.dcd_bin <= cur_bin_i;
            state_r.has_bkt <= 1'b0;
        end else if (apply_bkt_i) begin
            if (findflag_o == 2'd1) begin
                state_r.has_bkt <= 1'b1;          // flip
            end else if (findflag_o == 2'd0) begin
                state_r <= '0;                    // above the found level
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            bkt_bin_o <= '0;
            bkt_lvl_o <= '0;
        end else if (findflag_o == 2'd1) begin
            bkt_bin_o <= state_r.dcd_bin;
            bkt_lvl_o <= lvl_r;
        end else begin
            bkt_bin_o <= '0;
            bkt_lvl_o <= '0;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the trail testbench with Verilator
cd "$(dirname "$0")" || exit 1

OBJ=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_sat_trail \
    --Mdir "$OBJ" -o vsim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

"./$OBJ/vsim" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$SIM_LOG"; then
    exit 1
fi
exit 0

// File: sat_lvl_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trail widths, register map, bit fields
// and the structs shared by the datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package sat_lvl_pkg;

    localparam int NUM_LVLS     = 16;
    localparam int WIDTH_LVL    = 5;    // level 0 means no decision
    localparam int WIDTH_BIN_ID = 10;

    // word addresses
    localparam logic [2:0] ADDR_DECIDE = 3'd0;
    localparam logic [2:0] ADDR_BKT    = 3'd1;
    localparam logic [2:0] ADDR_LOAD   = 3'd2;
    localparam logic [2:0] ADDR_SEL    = 3'd3;
    localparam logic [2:0] ADDR_STATE  = 3'd4;
    localparam logic [2:0] ADDR_STATUS = 3'd5;
    localparam logic [2:0] ADDR_RESULT = 3'd6;

    // data word fields, bin always sits at bit 0
    localparam int LSB_LVL     = 16;
    localparam int BIT_HAS_BKT = 15;
    localparam int BIT_BUSY    = 8;
    localparam int BIT_UNSAT   = 9;
    localparam int BIT_FOUND   = 31;

    typedef struct packed {
        logic [WIDTH_BIN_ID-1:0] dcd_bin;
        logic                    has_bkt;  // decision already flipped
    } lvl_state_t;

    typedef struct packed {
        logic                    found;
        logic [WIDTH_LVL-1:0]    bkt_lvl;
        logic [WIDTH_BIN_ID-1:0] bkt_bin;
    } find_res_t;

    typedef struct packed {
        logic                    decide;
        logic                    backtrack;
        logic                    load;
        logic [WIDTH_BIN_ID-1:0] bin;
        logic [WIDTH_LVL-1:0]    lvl_sel;
        lvl_state_t              state;
    } trail_cmd_t;

endpackage

// File: sat_trail_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decision trail top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sat_trail_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [2:0]  wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o
);
    import sat_lvl_pkg::*;

    trail_cmd_t           cmd;
    find_res_t            find_res;
    find_res_t            result;
    lvl_state_t           rd_state;
    logic [WIDTH_LVL-1:0] rd_lvl;
    logic [WIDTH_LVL-1:0] cur_lvl;
    logic                 apply_bkt;
    logic                 clear_all;
    logic                 busy;
    logic                 unsat;

    trail_wb_slave u_slave (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .busy_i    (busy),
        .unsat_i   (unsat),
        .cur_lvl_i (cur_lvl),
        .result_i  (result),
        .rd_state_i(rd_state),
        .rd_lvl_o  (rd_lvl),
        .cmd_o     (cmd)
    );

    lvl_state_array u_array (
        .clk        (clk),
        .rst        (rst),
        .cmd_i      (cmd),
        .cur_lvl_i  (cur_lvl),
        .apply_bkt_i(apply_bkt),
        .clear_all_i(clear_all),
        .rd_lvl_i   (rd_lvl),
        .rd_state_o (rd_state),
        .find_o     (find_res)
    );

    bkt_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .cmd_i      (cmd),
        .find_i     (find_res),
        .cur_lvl_o  (cur_lvl),
        .apply_bkt_o(apply_bkt),
        .clear_all_o(clear_all),
        .busy_o     (busy),
        .unsat_o    (unsat),
        .result_o   (result)
    );

endmodule

// File: src.f
sat_lvl_pkg.sv
lvl_state_cell.sv
lvl_state_array.sv
bkt_sequencer.sv
trail_wb_slave.sv
sat_trail_top.sv
trail_checker.sv
tb_sat_trail.sv

// File: tb_sat_trail.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trail testbench with clock, reset and
// a wishbone master driven from the cases file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_sat_trail;
    import sat_lvl_pkg::*;

    localparam int MAX_CASES   = 64;
    localparam int RST_CYCLES  = 8;
    localparam int CASE_CYCLES = 50;   // watchdog budget per case

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        exp_valid;
    logic [31:0] exp_dat;
    logic [31:0] case_mem [4*MAX_CASES];  // op, addr, data, expected
    int          n_cases;
    int          data_errs;
    int          proto_errs;

    sat_trail_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    trail_checker u_check (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc_i     (wb_cyc),
        .wb_stb_i     (wb_stb),
        .wb_we_i      (wb_we),
        .wb_adr_i     (wb_adr),
        .wb_dat_i     (wb_dat_w),
        .rd_dat_i     (wb_dat_r),
        .wb_ack_i     (wb_ack),
        .exp_valid_i  (exp_valid),
        .exp_dat_i    (exp_dat),
        .data_errs_o  (data_errs),
        .proto_errs_o (proto_errs)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one classic cycle held through its ack
    task automatic bus_cycle(input logic we, input logic [2:0] adr, input logic [31:0] dat,
                             input logic chk, input logic [31:0] exp, output logic [31:0] rdata);
        @(posedge clk);
        #1;
        wb_cyc    = 1'b1;
        wb_stb    = 1'b1;
        wb_we     = we;
        wb_adr    = adr;
        wb_dat_w  = dat;
        exp_valid = chk;   // checker samples it with the ack
        exp_dat   = exp;
        do begin
            @(posedge clk);
            #1;
        end while (!wb_ack);
        rdata = wb_dat_r;
        @(posedge clk);    // ack is taken at this edge
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic backtrack_wait();
        logic [31:0] st;
        bus_cycle(1'b1, ADDR_BKT, 32'h0, 1'b0, 32'h0, st);
        do begin
            bus_cycle(1'b0, ADDR_STATUS, 32'h0, 1'b0, 32'h0, st);
        end while (st[BIT_BUSY]);
    endtask

    task automatic sweep_states(input logic [31:0] exp);
        logic [31:0] rd;
        for (int l = 1; l <= NUM_LVLS; l++) begin
            bus_cycle(1'b1, ADDR_SEL, 32'(l), 1'b0, 32'h0, rd);
            bus_cycle(1'b0, ADDR_STATE, 32'h0, 1'b1, exp, rd);
        end
    endtask

    initial begin : stimulus
        logic [31:0] op;
        logic [31:0] rd;
        rst       = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        exp_valid = 1'b0;
        exp_dat   = '0;
        $readmemh("trail_cases.txt", case_mem);
        while (n_cases < MAX_CASES && case_mem[4*n_cases] inside {[32'd1:32'd4]})
            n_cases++;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b1;
        for (int i = 0; i < n_cases; i++) begin
            op = case_mem[4*i];
            case (op)
                32'd1: bus_cycle(1'b1, case_mem[4*i+1][2:0], case_mem[4*i+2], 1'b0, 32'h0, rd);
                32'd2: bus_cycle(1'b0, case_mem[4*i+1][2:0], 32'h0, 1'b1, case_mem[4*i+3], rd);
                32'd3: backtrack_wait();
                default: sweep_states(case_mem[4*i+3]);
            endcase
        end
        repeat (2) @(posedge clk);  // let the checker see the last ack
        #1;
        if (n_cases == 0)
            $display("no cases were read from trail_cases.txt");
        $display("cases %0d, data errors %0d, protocol errors %0d",
                 n_cases, data_errs, proto_errs);
        if (n_cases > 0 && data_errs == 0 && proto_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (n_cases > 0);
        repeat (RST_CYCLES + n_cases * CASE_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles",
                 RST_CYCLES + n_cases * CASE_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

// File: trail_cases.txt
// op addr data expected, all hex
// op 1 write, 2 read and compare, 3 backtrack and poll, 4 STATE at every level, 0 end
2 5 00000000 00000000
4 4 00000000 00000000
// four decisions
1 0 00000011 00000000
1 0 00000022 00000000
1 0 00000033 00000000
1 0 00000044 00000000
2 5 00000000 00000004
1 3 00000002 00000000
2 4 00000000 00000022
// load level 3 as already flipped
1 2 000380ab 00000000
1 3 00000003 00000000
2 4 00000000 000080ab
// backtracks walk down past flipped levels
3 1 00000000 00000000
2 6 00000000 80040044
3 1 00000000 00000000
2 6 00000000 80020022
2 5 00000000 00000002
2 4 00000000 00000000
// decide issued while the backtrack is busy
1 1 00000000 00000000
1 0 00000155 00000000
1 3 00000002 00000000
2 4 00000000 00000155
// run out of levels
3 1 00000000 00000000
3 1 00000000 00000000
2 5 00000000 00000200
2 6 00000000 00000000
4 4 00000000 00000000
1 0 000003ff 00000000
2 5 00000000 00000001
0 0 00000000 00000000

// File: trail_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus monitor with a reference trail
// model, compares every read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module trail_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [2:0]  wb_adr_i,
    input  logic [31:0] wb_dat_i,
    input  logic [31:0] rd_dat_i,
    input  logic        wb_ack_i,
    input  logic        exp_valid_i,
    input  logic [31:0] exp_dat_i,
    output int          data_errs_o,
    output int          proto_errs_o
);
    import sat_lvl_pkg::*;

    localparam int ACK_LIMIT   = 16;
    localparam int BUSY_CYCLES = 3;   // busy until the apply edge

    logic [WIDTH_BIN_ID-1:0] m_bin  [NUM_LVLS+1];   // index 0 unused
    logic                    m_flip [NUM_LVLS+1];
    int                      m_lvl;
    int                      m_sel;
    logic                    m_unsat;
    logic [31:0]             m_result;
    logic [31:0]             busy_status;   // status seen while busy
    int                      busy_cnt;
    int                      wait_cnt;

    function automatic string reg_name(input logic [2:0] adr);
        case (adr)
            ADDR_SEL:    return "SEL";
            ADDR_STATE:  return "STATE";
            ADDR_STATUS: return "STATUS";
            ADDR_RESULT: return "RESULT";
            default:     return "unmapped";
        endcase
    endfunction

    function automatic logic [31:0] status_word();
        return (32'(m_unsat) << BIT_UNSAT) | 32'(m_lvl);
    endfunction

    function automatic logic [31:0] model_read(input logic [2:0] adr);
        logic [31:0] w;
        w = '0;
        case (adr)
            ADDR_SEL:    w = 32'(m_sel);
            ADDR_STATE:  if (m_sel >= 1 && m_sel <= NUM_LVLS)
                             w = (32'(m_flip[m_sel]) << BIT_HAS_BKT) | 32'(m_bin[m_sel]);
            ADDR_STATUS: w = (busy_cnt > 0) ? busy_status : status_word();
            ADDR_RESULT: w = m_result;
            default:     w = '0;
        endcase
        return w;
    endfunction

    // deepest unflipped level at or below the current one
    task automatic model_backtrack();
        int hit;
        hit = 0;
        for (int l = m_lvl; l >= 1; l--)
            if (hit == 0 && !m_flip[l]) hit = l;
        for (int l = hit + 1; l <= NUM_LVLS; l++) begin
            m_bin[l]  = '0;
            m_flip[l] = 1'b0;
        end
        if (hit != 0) begin
            m_flip[hit] = 1'b1;
            m_result = (32'(1) << BIT_FOUND) | (32'(hit) << LSB_LVL) | 32'(m_bin[hit]);
        end else begin
            m_result = '0;
        end
        m_lvl   = hit;
        m_unsat = (hit == 0);
    endtask

    task automatic model_write();
        int l;
        l = int'(wb_dat_i[LSB_LVL +: WIDTH_LVL]);
        case (wb_adr_i)
            ADDR_DECIDE: begin
                if (m_lvl < NUM_LVLS) begin     // full trail drops the decision
                    m_lvl++;
                    m_bin[m_lvl]  = wb_dat_i[WIDTH_BIN_ID-1:0];
                    m_flip[m_lvl] = 1'b0;
                end
                m_unsat = 1'b0;
            end
            ADDR_LOAD: begin
                if (l >= 1 && l <= NUM_LVLS) begin
                    m_bin[l]  = wb_dat_i[WIDTH_BIN_ID-1:0];
                    m_flip[l] = wb_dat_i[BIT_HAS_BKT];
                end
                m_unsat = 1'b0;
            end
            ADDR_SEL: m_sel = int'(wb_dat_i[WIDTH_LVL-1:0]);
            ADDR_BKT: begin
                busy_status = status_word() | (32'(1) << BIT_BUSY);
                busy_cnt    = BUSY_CYCLES;
                model_backtrack();
            end
            default: ;
        endcase
    endtask

    task automatic check_read();
        logic [31:0] exp;
        exp = model_read(wb_adr_i);
        if (rd_dat_i !== exp) begin
            $display("[ERROR] wb_dat_o %s model exp %h got %h", reg_name(wb_adr_i), exp, rd_dat_i);
            data_errs_o++;
        end
        if (exp_valid_i && rd_dat_i !== exp_dat_i) begin
            $display("[ERROR] wb_dat_o %s case exp %h got %h",
                     reg_name(wb_adr_i), exp_dat_i, rd_dat_i);
            data_errs_o++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            for (int l = 0; l <= NUM_LVLS; l++) begin
                m_bin[l]  = '0;
                m_flip[l] = 1'b0;
            end
            m_lvl       = 0;
            m_sel       = 0;
            m_unsat     = 1'b0;
            m_result    = '0;
            busy_status = '0;
            busy_cnt    = 0;
            wait_cnt    = 0;
        end else begin
            if (wb_cyc_i && wb_stb_i && !wb_ack_i) begin
                wait_cnt++;
                if (wait_cnt == ACK_LIMIT) begin
                    $display("no ack from the DUT within %0d cycles at address %0d",
                             ACK_LIMIT, wb_adr_i);
                    proto_errs_o++;
                end
            end else begin
                wait_cnt = 0;
            end
            if (wb_ack_i && !wb_we_i)
                check_read();
            if (wb_ack_i && wb_we_i && busy_cnt > 0 &&
                wb_adr_i inside {ADDR_DECIDE, ADDR_BKT, ADDR_LOAD}) begin
                $display("command at address %0d was acknowledged while a backtrack was busy",
                         wb_adr_i);
                proto_errs_o++;
            end
            if (busy_cnt > 0) busy_cnt--;
            if (wb_ack_i && wb_we_i)
                model_write();
        end
    end

endmodule

// File: trail_wb_slave.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone classic slave, register map
// and command pulses to the datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module trail_wb_slave (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              wb_cyc_i,
    input  logic                              wb_stb_i,
    input  logic                              wb_we_i,
    input  logic [2:0]                        wb_adr_i,
    input  logic [31:0]                       wb_dat_i,
    output logic [31:0]                       wb_dat_o,
    output logic                              wb_ack_o,

    input  logic                              busy_i,
    input  logic                              unsat_i,
    input  logic [sat_lvl_pkg::WIDTH_LVL-1:0] cur_lvl_i,
    input  sat_lvl_pkg::find_res_t            result_i,
    input  sat_lvl_pkg::lvl_state_t           rd_state_i,
    output logic [sat_lvl_pkg::WIDTH_LVL-1:0] rd_lvl_o,
    output sat_lvl_pkg::trail_cmd_t           cmd_o
);
    import sat_lvl_pkg::*;

    logic                 ack_q;
    logic                 req;
    logic                 is_cmd;
    logic                 ack_d;
    logic [WIDTH_LVL-1:0] sel_q;
    trail_cmd_t           cmd_q;
    logic [31:0]          rd_word;
    logic [31:0]          dat_q;

    // no new request in the ack cycle itself
    assign req    = wb_cyc_i && wb_stb_i && !ack_q;
    assign is_cmd = wb_we_i &&
                    (wb_adr_i == ADDR_DECIDE || wb_adr_i == ADDR_BKT || wb_adr_i == ADDR_LOAD);
    assign ack_d  = req && !(is_cmd && busy_i);  // stall commands while busy

    always_ff @(posedge clk) begin
        if (!rst) begin
            ack_q <= 1'b0;
            sel_q <= '0;
            cmd_q <= '0;
        end else begin
            ack_q <= ack_d;
            cmd_q <= '0;                          // one cycle pulse
            if (ack_d && wb_we_i) begin
                case (wb_adr_i)
                    ADDR_DECIDE: cmd_q.decide    <= 1'b1;
                    ADDR_BKT:    cmd_q.backtrack <= 1'b1;
                    ADDR_LOAD:   cmd_q.load      <= 1'b1;
                    ADDR_SEL:    sel_q           <= wb_dat_i[WIDTH_LVL-1:0];
                    default: ;
                endcase
                cmd_q.bin           <= wb_dat_i[WIDTH_BIN_ID-1:0];
                cmd_q.lvl_sel       <= wb_dat_i[LSB_LVL +: WIDTH_LVL];
                cmd_q.state.dcd_bin <= wb_dat_i[WIDTH_BIN_ID-1:0];
                cmd_q.state.has_bkt <= wb_dat_i[BIT_HAS_BKT];
            end
        end
    end

    always_comb begin
        rd_word = '0;
        case (wb_adr_i)
            ADDR_SEL: rd_word[WIDTH_LVL-1:0] = sel_q;
            ADDR_STATE: begin
                rd_word[WIDTH_BIN_ID-1:0] = rd_state_i.dcd_bin;
                rd_word[BIT_HAS_BKT]      = rd_state_i.has_bkt;
            end
            ADDR_STATUS: begin
                rd_word[WIDTH_LVL-1:0] = cur_lvl_i;
                rd_word[BIT_BUSY]      = busy_i;
                rd_word[BIT_UNSAT]     = unsat_i;
            end
            ADDR_RESULT: begin
                rd_word[WIDTH_BIN_ID-1:0]       = result_i.bkt_bin;
                rd_word[LSB_LVL +: WIDTH_LVL]   = result_i.bkt_lvl;
                rd_word[BIT_FOUND]              = result_i.found;
            end
            default: ;
        endcase
    end

    // read data is presented together with ack
    always_ff @(posedge clk) begin
        if (ack_d && !wb_we_i) dat_q <= rd_word;
    end

    assign wb_ack_o = ack_q;
    assign wb_dat_o = dat_q;
    assign rd_lvl_o = sel_q;
    assign cmd_o    = cmd_q;

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i));

endmodule
